// File: Makefile
# Verilator simulation of the shared memory path
# Any variable below can be overridden on the command line

VERILATOR ?= verilator
TOP ?= tb_mem_subsystem
FILELIST ?= mem_subsystem.f
OBJ_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert -j 0

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); exit $$status
	@if grep -q "Finished with errors" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi
	@echo "Simulation passed"

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: common/mem_pkg.sv
//////////////////////////////
// Memory path package
// Bus widths and RAM geometry shared by
// the arbiters, the RAM slave and the top level
//////////////////////////////

`default_nettype none

package mem_pkg;

	// Split request/response bus
	localparam int addr_w = 32;
	localparam int data_w = 32;
	localparam int be_w = data_w / 8;	// One enable per byte lane

	// RAM slave geometry, word addressed
	localparam int ram_words = 256;
	localparam int ram_idx_w = $clog2(ram_words);

endpackage

`default_nettype wire

// File: design/mem_arbiter/mem_arbiter.sv
//////////////////////////////
// Two-port round-robin arbiter
// Merges two split request/response masters
// onto one slave port. Grants are blocked
// while a read is outstanding and the
// response is steered back to its owner
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module mem_arbiter
(
	input logic clk_i
	, input logic rst_i

	, input logic m0_req
	, input logic m0_we
	, input logic [mem_pkg::addr_w-1:0] m0_addr
	, input logic [mem_pkg::be_w-1:0] m0_be
	, input logic [mem_pkg::data_w-1:0] m0_wdata
	, output logic m0_ack
	, output logic m0_resp
	, output logic [mem_pkg::data_w-1:0] m0_rdata

	, input logic m1_req
	, input logic m1_we
	, input logic [mem_pkg::addr_w-1:0] m1_addr
	, input logic [mem_pkg::be_w-1:0] m1_be
	, input logic [mem_pkg::data_w-1:0] m1_wdata
	, output logic m1_ack
	, output logic m1_resp
	, output logic [mem_pkg::data_w-1:0] m1_rdata

	, output logic s_req
	, output logic s_we
	, output logic [mem_pkg::addr_w-1:0] s_addr
	, output logic [mem_pkg::be_w-1:0] s_be
	, output logic [mem_pkg::data_w-1:0] s_wdata
	, input logic s_ack
	, input logic s_resp
	, input logic [mem_pkg::data_w-1:0] s_rdata
);
	import mem_pkg::*;

	logic m0_rd_pend;
	logic m1_rd_pend;
	logic prio;		// Port that wins a tie, 0 after reset
	logic gnt_valid;
	logic gnt_sel;		// Index of the granted port

	// Only one read may be in flight, so any pending read freezes the grant
	always_comb
		begin
		gnt_valid = 1'b0;
		gnt_sel = 1'b0;
		if (!m0_rd_pend && !m1_rd_pend && (m0_req || m1_req))
			begin
			gnt_valid = 1'b1;
			if (prio)
				gnt_sel = m1_req;
			else
				gnt_sel = !m0_req;
			end
		end

	always_comb
		begin
		s_req = 1'b0;
		s_we = 1'b0;
		s_addr = {addr_w{1'b0}};
		s_be = {be_w{1'b0}};
		s_wdata = {data_w{1'b0}};
		if (gnt_valid)
			begin
			s_req = 1'b1;
			s_we = gnt_sel ? m1_we : m0_we;
			s_addr = gnt_sel ? m1_addr : m0_addr;
			s_be = gnt_sel ? m1_be : m0_be;
			s_wdata = gnt_sel ? m1_wdata : m0_wdata;
			end
		end

	assign m0_ack = gnt_valid && !gnt_sel && s_ack;
	assign m1_ack = gnt_valid && gnt_sel && s_ack;

	// Response goes only to the port that owns the read
	assign m0_resp = m0_rd_pend && s_resp;
	assign m1_resp = m1_rd_pend && s_resp;
	assign m0_rdata = m0_rd_pend ? s_rdata : {data_w{1'b0}};
	assign m1_rdata = m1_rd_pend ? s_rdata : {data_w{1'b0}};

	always_ff @(posedge clk_i)
		begin
		if (rst_i)
			begin
			m0_rd_pend <= 1'b0;
			m1_rd_pend <= 1'b0;
			prio <= 1'b0;
			end
		else
			begin
			if (s_resp)
				begin
				m0_rd_pend <= 1'b0;
				m1_rd_pend <= 1'b0;
				end
			if (gnt_valid && s_ack)
				begin
				prio <= !gnt_sel;	// Other port goes first next time
				if (!s_we)
					begin
					if (gnt_sel)
						m1_rd_pend <= 1'b1;
					else
						m0_rd_pend <= 1'b1;
					end
				end
			end
		end

endmodule

`default_nettype wire

// File: design/mem_ram/mem_ram.sv
//////////////////////////////
// RAM slave
// Word-addressed memory on the split bus.
// Accepts every request at once, writes
// enabled bytes and answers reads with a
// registered response one cycle later
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module mem_ram
(
	input logic clk_i
	, input logic rst_i

	, input logic req
	, input logic we
	, input logic [mem_pkg::addr_w-1:0] addr
	, input logic [mem_pkg::be_w-1:0] be
	, input logic [mem_pkg::data_w-1:0] wdata
	, output logic ack
	, output logic resp
	, output logic [mem_pkg::data_w-1:0] rdata
);
	import mem_pkg::*;

	logic [data_w-1:0] mem [ram_words];
	logic [ram_idx_w-1:0] idx;
	logic rd_acc;

	// Byte offset below the index and address bits above it are dropped
	assign idx = addr[$clog2(be_w) +: ram_idx_w];

	// The RAM never stalls
	assign ack = req;
	assign rd_acc = req && !we;

	always_ff @(posedge clk_i)
		begin
		if (req && we)
			begin
			for (int i = 0; i < be_w; i++)
				begin
				if (be[i])
					mem[idx][8*i +: 8] <= wdata[8*i +: 8];
				end
			end
		end

	// Word as it stood at the ack edge, held until the next read
	always_ff @(posedge clk_i)
		begin
		if (rd_acc)
			rdata <= mem[idx];
		end

	always_ff @(posedge clk_i)
		begin
		if (rst_i)
			resp <= 1'b0;
		else
			resp <= rd_acc;	// One-cycle pulse after each read ack
		end

endmodule

`default_nettype wire

// File: design/mem_subsystem.sv
//////////////////////////////
// Shared memory path
// Four requesters reach one RAM through a
// two-level tree of round-robin arbiters
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module mem_subsystem
(
	input logic clk_i
	, input logic rst_i

	, input logic r0_req
	, input logic r0_we
	, input logic [mem_pkg::addr_w-1:0] r0_addr
	, input logic [mem_pkg::be_w-1:0] r0_be
	, input logic [mem_pkg::data_w-1:0] r0_wdata
	, output logic r0_ack
	, output logic r0_resp
	, output logic [mem_pkg::data_w-1:0] r0_rdata

	, input logic r1_req
	, input logic r1_we
	, input logic [mem_pkg::addr_w-1:0] r1_addr
	, input logic [mem_pkg::be_w-1:0] r1_be
	, input logic [mem_pkg::data_w-1:0] r1_wdata
	, output logic r1_ack
	, output logic r1_resp
	, output logic [mem_pkg::data_w-1:0] r1_rdata

	, input logic r2_req
	, input logic r2_we
	, input logic [mem_pkg::addr_w-1:0] r2_addr
	, input logic [mem_pkg::be_w-1:0] r2_be
	, input logic [mem_pkg::data_w-1:0] r2_wdata
	, output logic r2_ack
	, output logic r2_resp
	, output logic [mem_pkg::data_w-1:0] r2_rdata

	, input logic r3_req
	, input logic r3_we
	, input logic [mem_pkg::addr_w-1:0] r3_addr
	, input logic [mem_pkg::be_w-1:0] r3_be
	, input logic [mem_pkg::data_w-1:0] r3_wdata
	, output logic r3_ack
	, output logic r3_resp
	, output logic [mem_pkg::data_w-1:0] r3_rdata
);
	import mem_pkg::*;

	// First-level arbiter a towards the root
	logic l1a_req;
	logic l1a_we;
	logic [addr_w-1:0] l1a_addr;
	logic [be_w-1:0] l1a_be;
	logic [data_w-1:0] l1a_wdata;
	logic l1a_ack;
	logic l1a_resp;
	logic [data_w-1:0] l1a_rdata;

	logic l1b_req;
	logic l1b_we;
	logic [addr_w-1:0] l1b_addr;
	logic [be_w-1:0] l1b_be;
	logic [data_w-1:0] l1b_wdata;
	logic l1b_ack;
	logic l1b_resp;
	logic [data_w-1:0] l1b_rdata;

	// Root arbiter to RAM
	logic ram_req;
	logic ram_we;
	logic [addr_w-1:0] ram_addr;
	logic [be_w-1:0] ram_be;
	logic [data_w-1:0] ram_wdata;
	logic ram_ack;
	logic ram_resp;
	logic [data_w-1:0] ram_rdata;

	mem_arbiter l1_a
	(
		.clk_i(clk_i), .rst_i(rst_i)
		, .m0_req(r0_req), .m0_we(r0_we), .m0_addr(r0_addr), .m0_be(r0_be)
		, .m0_wdata(r0_wdata), .m0_ack(r0_ack), .m0_resp(r0_resp), .m0_rdata(r0_rdata)
		, .m1_req(r1_req), .m1_we(r1_we), .m1_addr(r1_addr), .m1_be(r1_be)
		, .m1_wdata(r1_wdata), .m1_ack(r1_ack), .m1_resp(r1_resp), .m1_rdata(r1_rdata)
		, .s_req(l1a_req), .s_we(l1a_we), .s_addr(l1a_addr), .s_be(l1a_be)
		, .s_wdata(l1a_wdata), .s_ack(l1a_ack), .s_resp(l1a_resp), .s_rdata(l1a_rdata)
	);

	mem_arbiter l1_b
	(
		.clk_i(clk_i), .rst_i(rst_i)
		, .m0_req(r2_req), .m0_we(r2_we), .m0_addr(r2_addr), .m0_be(r2_be)
		, .m0_wdata(r2_wdata), .m0_ack(r2_ack), .m0_resp(r2_resp), .m0_rdata(r2_rdata)
		, .m1_req(r3_req), .m1_we(r3_we), .m1_addr(r3_addr), .m1_be(r3_be)
		, .m1_wdata(r3_wdata), .m1_ack(r3_ack), .m1_resp(r3_resp), .m1_rdata(r3_rdata)
		, .s_req(l1b_req), .s_we(l1b_we), .s_addr(l1b_addr), .s_be(l1b_be)
		, .s_wdata(l1b_wdata), .s_ack(l1b_ack), .s_resp(l1b_resp), .s_rdata(l1b_rdata)
	);

	// Ack runs combinationally from the RAM through both levels
	mem_arbiter l2
	(
		.clk_i(clk_i), .rst_i(rst_i)
		, .m0_req(l1a_req), .m0_we(l1a_we), .m0_addr(l1a_addr), .m0_be(l1a_be)
		, .m0_wdata(l1a_wdata), .m0_ack(l1a_ack), .m0_resp(l1a_resp)
		, .m0_rdata(l1a_rdata)
		, .m1_req(l1b_req), .m1_we(l1b_we), .m1_addr(l1b_addr), .m1_be(l1b_be)
		, .m1_wdata(l1b_wdata), .m1_ack(l1b_ack), .m1_resp(l1b_resp)
		, .m1_rdata(l1b_rdata)
		, .s_req(ram_req), .s_we(ram_we), .s_addr(ram_addr), .s_be(ram_be)
		, .s_wdata(ram_wdata), .s_ack(ram_ack), .s_resp(ram_resp), .s_rdata(ram_rdata)
	);

	mem_ram ram
	(
		.clk_i(clk_i), .rst_i(rst_i)
		, .req(ram_req), .we(ram_we), .addr(ram_addr), .be(ram_be), .wdata(ram_wdata)
		, .ack(ram_ack), .resp(ram_resp), .rdata(ram_rdata)
	);

endmodule

`default_nettype wire

// File: mem_subsystem.f
common/mem_pkg.sv
design/mem_arbiter/mem_arbiter.sv
design/mem_ram/mem_ram.sv
design/mem_subsystem.sv
verification/tb_mem_subsystem.sv

// File: verification/tb_mem_subsystem.sv
//////////////////////////////
// Memory path testbench
// Drives four requesters against a shadow
// memory and checks protocol, fairness
// and read data with assertions
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module tb_mem_subsystem;
	import mem_pkg::*;

	localparam int clk_period = 40;
	localparam int n_tests = 5;
	localparam int n_trans = 128;	// Upper bound on transfers in any one test
	localparam int timeout_ns = n_tests * n_trans * 64 * clk_period;
	localparam int off_w = $clog2(be_w);
	localparam int upper_w = addr_w - ram_idx_w - off_w;
	localparam logic [3:0] part_be [4] = '{4'b0001, 4'b0110, 4'b1000, 4'b1011};

	logic clk_i;
	logic rst_i;

	logic req [4];
	logic we [4];
	logic [addr_w-1:0] addr [4];
	logic [be_w-1:0] be [4];
	logic [data_w-1:0] wdata [4];
	wire [3:0] ack_v;
	wire [3:0] resp_v;
	wire [data_w-1:0] rdata [4];
	wire [3:0] req_v = {req[3], req[2], req[1], req[0]};

	// Reference state kept beside the DUT
	logic [data_w-1:0] shadow [ram_words];
	logic [data_w-1:0] exp_rd [4];
	logic [3:0] pend;		// Read acknowledged, resp not yet seen
	logic last_a;
	logic last_b;
	logic last_side;	// 0 when the l1_a side won last at the root

	int err_cnt = 0;
	int tests_run = 0;

	mem_subsystem DUT
	(
		.clk_i(clk_i), .rst_i(rst_i)
		, .r0_req(req[0]), .r0_we(we[0]), .r0_addr(addr[0]), .r0_be(be[0])
		, .r0_wdata(wdata[0]), .r0_ack(ack_v[0]), .r0_resp(resp_v[0]), .r0_rdata(rdata[0])
		, .r1_req(req[1]), .r1_we(we[1]), .r1_addr(addr[1]), .r1_be(be[1])
		, .r1_wdata(wdata[1]), .r1_ack(ack_v[1]), .r1_resp(resp_v[1]), .r1_rdata(rdata[1])
		, .r2_req(req[2]), .r2_we(we[2]), .r2_addr(addr[2]), .r2_be(be[2])
		, .r2_wdata(wdata[2]), .r2_ack(ack_v[2]), .r2_resp(resp_v[2]), .r2_rdata(rdata[2])
		, .r3_req(req[3]), .r3_we(we[3]), .r3_addr(addr[3]), .r3_be(be[3])
		, .r3_wdata(wdata[3]), .r3_ack(ack_v[3]), .r3_resp(resp_v[3]), .r3_rdata(rdata[3])
	);

	initial
		begin
		clk_i = 1'b0;
		forever #(clk_period / 2) clk_i = ~clk_i;
		end

	function automatic logic [data_w-1:0] merge_bytes(input logic [data_w-1:0] old_w,
		input logic [data_w-1:0] new_w, input logic [be_w-1:0] en);
		logic [data_w-1:0] w;
		w = old_w;
		for (int b = 0; b < be_w; b++)
			begin
			if (en[b])
				w[8*b +: 8] = new_w[8*b +: 8];
			end
		return w;
	endfunction

	// Every index bit changes the word
	function automatic logic [data_w-1:0] fill_word(input logic [ram_idx_w-1:0] idx);
		return {idx ^ 8'h3c, ~idx, idx + 8'h11, idx};
	endfunction

	task automatic count_error(input string msg);
		err_cnt++;
		$display("%s", msg);
	endtask

	task automatic end_test(input int n, input string name, input int err_start);
		tests_run++;
		$display("Test %0d %s done, %0d errors", n, name, err_cnt - err_start);
	endtask

	// One transfer on requester p, entered and left on a rising edge
	task automatic access(input int p, input logic wr, input logic [ram_idx_w-1:0] idx,
		input logic [upper_w-1:0] upper, input logic [be_w-1:0] b, input logic [data_w-1:0] d);
		req[p] <= 1'b1;
		we[p] <= wr;
		addr[p] <= {upper, idx, {off_w{1'b0}}};
		be[p] <= b;
		wdata[p] <= d;
		do
			@(posedge clk_i);
		while (!ack_v[p]);
		req[p] <= 1'b0;	// A following call in this time step raises it again
		if (!wr)
			begin
			do
				@(posedge clk_i);
			while (!resp_v[p]);
			end
	endtask

	task automatic write_burst(input int p, input int n);
		logic [data_w-1:0] d;
		for (int i = 0; i < n; i++)
			begin
			d = $urandom;
			access(p, 1'b1, 8'h40 + 8'(p * 16 + i), '0, 4'hf, d);
			end
	endtask

	task automatic random_traffic(input int p, input int n);
		logic [31:0] r;
		logic [data_w-1:0] d;
		for (int i = 0; i < n; i++)
			begin
			r = $urandom;
			d = $urandom;
			// Sixteen shared words keep the requesters colliding
			access(p, r[0], {4'h0, r[4:1]}, r[31:10], r[8:5], d);
			if (r[9])
				@(posedge clk_i);
			end
	endtask

	// Reference model of the shared RAM and the round-robin state
	always @(posedge clk_i)
		begin : monitor
		int k;
		logic hit;
		logic [ram_idx_w-1:0] idx;
		logic [3:0] rd_set;
		hit = 1'b0;
		k = 0;
		for (int p = 0; p < 4; p++)
			begin
			if (ack_v[p])
				begin
				hit = 1'b1;
				k = p;
				end
			end
		idx = addr[k][off_w +: ram_idx_w];
		rd_set = 4'b0;
		if (hit && !we[k])
			rd_set[k] = 1'b1;
		if (rst_i)
			begin
			pend <= 4'b0;
			last_a <= 1'b1;
			last_b <= 1'b1;
			last_side <= 1'b1;
			end
		else
			begin
			pend <= (pend & ~resp_v) | rd_set;
			if (hit && we[k])
				shadow[idx] <= merge_bytes(shadow[idx], wdata[k], be[k]);
			if (hit && !we[k])
				exp_rd[k] <= shadow[idx];	// Word as it stands at the read ack
			if (ack_v[0] || ack_v[1])
				begin
				last_a <= ack_v[1];
				last_side <= 1'b0;
				end
			if (ack_v[2] || ack_v[3])
				begin
				last_b <= ack_v[3];
				last_side <= 1'b1;
				end
			end
		end

	// A port may not win twice in a row while its partner waits
	wire repeat_a = (ack_v[0] && req[1] && !last_a) || (ack_v[1] && req[0] && last_a);
	wire repeat_b = (ack_v[2] && req[3] && !last_b) || (ack_v[3] && req[2] && last_b);
	wire repeat_side = ((ack_v[0] || ack_v[1]) && (req[2] || req[3]) && !last_side)
		|| ((ack_v[2] || ack_v[3]) && (req[0] || req[1]) && last_side);

	idle_quiet: assert property (@(posedge clk_i) disable iff (rst_i)
		(req_v == 4'b0) && (pend == 4'b0) |-> (ack_v == 4'b0) && (resp_v == 4'b0))
		else count_error("Ack or resp seen with no request and no read outstanding");
	one_ack: assert property (@(posedge clk_i) disable iff (rst_i) $onehot0(ack_v))
		else count_error("More than one requester acknowledged in the same cycle");
	lone_ack: assert property (@(posedge clk_i) disable iff (rst_i)
		$onehot(req_v) && (pend == 4'b0) |-> (ack_v == req_v))
		else count_error("A lone request was not acknowledged in the cycle it was presented");
	fair_l1_a: assert property (@(posedge clk_i) disable iff (rst_i) !repeat_a)
		else count_error("Arbiter l1_a granted r0 or r1 twice while the other waited");
	fair_l1_b: assert property (@(posedge clk_i) disable iff (rst_i) !repeat_b)
		else count_error("Arbiter l1_b granted r2 or r3 twice while the other waited");
	fair_l2: assert property (@(posedge clk_i) disable iff (rst_i) !repeat_side)
		else count_error("Root arbiter granted one side twice while the other waited");

	for (genvar p = 0; p < 4; p++)
		begin : g_port
		ack_has_req: assert property (@(posedge clk_i) disable iff (rst_i)
			ack_v[p] |-> req[p])
			else count_error($sformatf("Requester %0d acknowledged without a request", p));
		resp_owner: assert property (@(posedge clk_i) disable iff (rst_i)
			resp_v[p] |-> pend[p])
			else count_error($sformatf("Response on requester %0d with no read open", p));
		read_latency: assert property (@(posedge clk_i) disable iff (rst_i)
			ack_v[p] && !we[p] |=> resp_v[p])
			else count_error($sformatf("Requester %0d resp missing one cycle after ack", p));
		read_data: assert property (@(posedge clk_i) disable iff (rst_i)
			resp_v[p] |-> rdata[p] === exp_rd[p])
			else count_error($sformatf("Fail r%0d_rdata: got %h, expected %h",
				p, $sampled(rdata[p]), $sampled(exp_rd[p])));
		end

	initial
		begin
		#(timeout_ns);
		$display("Watchdog expired before the tests completed");
		$display("Finished with errors");
		$finish;
		end

	initial
		begin : main
		int err_start;
		logic [31:0] r;
		logic [data_w-1:0] d;
		void'($urandom(32'h25be));
		for (int i = 0; i < 4; i++)
			begin
			req[i] <= 1'b0;
			we[i] <= 1'b0;
			addr[i] <= '0;
			be[i] <= '0;
			wdata[i] <= '0;
			end
		rst_i <= 1'b1;
		repeat (16) @(posedge clk_i);
		rst_i <= 1'b0;

		err_start = err_cnt;
		repeat (8) @(posedge clk_i);
		end_test(1, "reset_quiet", err_start);

		// Read back through different upper address bits
		err_start = err_cnt;
		for (int p = 0; p < 4; p++)
			begin
			r = $urandom;
			d = $urandom;
			access(p, 1'b1, 8'h20 + p[7:0], r[31:10], 4'hf, d);
			access(p, 1'b0, 8'h20 + p[7:0], ~r[31:10], 4'hf, '0);
			end
		end_test(2, "single_requester", err_start);

		err_start = err_cnt;
		for (int p = 0; p < 4; p++)
			begin
			d = $urandom;
			access(p, 1'b1, 8'h30 + p[7:0], '0, 4'hf, d);
			d = $urandom;
			access(p, 1'b1, 8'h30 + p[7:0], '0, part_be[p], d);
			d = $urandom;
			access((p + 1) % 4, 1'b1, 8'h30 + p[7:0], '0, part_be[3 - p], d);
			access(p, 1'b0, 8'h30 + p[7:0], '0, 4'hf, '0);
			end
		end_test(3, "byte_enables", err_start);

		err_start = err_cnt;
		fork
			write_burst(0, 8);
			write_burst(1, 8);
			write_burst(2, 8);
			write_burst(3, 8);
		join
		end_test(4, "fairness", err_start);

		err_start = err_cnt;
		for (int i = 0; i < 16; i++)
			access(0, 1'b1, i[7:0], '0, 4'hf, fill_word(i[7:0]));
		fork
			random_traffic(0, 24);
			random_traffic(1, 24);
			random_traffic(2, 24);
			random_traffic(3, 24);
		join
		repeat (4) @(posedge clk_i);
		end_test(5, "random_traffic", err_start);

		$display("Tests run %0d, errors %0d", tests_run, err_cnt);
		if (err_cnt == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
		end

endmodule

`default_nettype wire
